// File: pcie_cfg.f
verilog/pcie_cfg_pkg.sv
verilog/cfg_cmd_decode.sv
verilog/cfg_csr_file.sv
verilog/cfg_mgmt_seq.sv
verilog/pcie_cfg_top.sv
verif/tb_cfg_core_model.sv
verif/tb_pcie_cfg.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_pcie_cfg -Mdir obj_dir -f pcie_cfg.f \
    && ./obj_dir/Vtb_pcie_cfg | tee /dev/stderr | grep -qx "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verif/tb_pcie_cfg.sv
module tb_pcie_cfg
    import pcie_cfg_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {K_RD, K_WR, K_POLL} kind_t;

    typedef struct packed {
        kind_t       kind;
        logic [15:0] addr;                                 // bit 15 selects rw
        logic [15:0] mask;
        logic [15:0] value;                                // byte at addr in bits 7:0
        logic [31:0] exp;                                  // expected o_rsp_data
    } row_t;

    logic          clk_pcie = 1'b0;
    logic          rst;
    logic          cmd_valid;
    logic [63:0]   cmd_word;
    cfg_status_t   status;
    logic [31:0]   mgmt_do;
    logic          mgmt_done;
    cfg_mgmt_req_t cfg_mgmt;
    logic          rsp_valid;
    logic [31:0]   rsp_data;
    logic [15:0]   pcie_id;
    logic [31:0]   last_di;
    logic [9:0]    last_dwaddr;
    logic [3:0]    last_byte_en;

    row_t        rows[$];
    int          idx_q[$];                                 // rows of pending reads
    int          due_q[$];                                 // cycle each response is due
    logic [31:0] exp_q[$];
    logic [31:0] last_poll;
    int          poll_limit  = 20;
    int          n_tests     = 0;
    int          n_errors    = 0;
    int          cycles      = 0;
    int          cycle_limit = 0;

    always #10 clk_pcie = ~clk_pcie;

    pcie_cfg_top dut (
        .clk_pcie              (clk_pcie),
        .rst                   (rst),
        .i_cmd_valid           (cmd_valid),
        .i_cmd_word            (cmd_word),
        .i_status              (status),
        .i_cfg_mgmt_do         (mgmt_do),
        .i_cfg_mgmt_rd_wr_done (mgmt_done),
        .o_cfg_mgmt            (cfg_mgmt),
        .o_rsp_valid           (rsp_valid),
        .o_rsp_data            (rsp_data),
        .o_pcie_id             (pcie_id)
    );

    tb_cfg_core_model u_core (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .i_cfg_mgmt     (cfg_mgmt),
        .o_do           (mgmt_do),
        .o_done         (mgmt_done),
        .o_last_di      (last_di),
        .o_last_dwaddr  (last_dwaddr),
        .o_last_byte_en (last_byte_en)
    );

    always @(posedge clk_pcie)
    begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // stimulus table
    // ----------------------------------------------------------------------
    task automatic add_row(input kind_t kind, input logic [15:0] addr, input logic [15:0] mask,
                           input logic [15:0] value, input logic [31:0] exp);
        rows.push_back({kind, addr, mask, value, exp});
    endtask

    task automatic build_table();
        add_row(K_RD,   16'h0000, 16'h0000, 16'h0000, 32'h0000_0123);  // ro magic
        add_row(K_RD,   16'h0004, 16'h0000, 16'h0000, 32'h0004_1400);  // ro bytecount
        add_row(K_RD,   16'h0002, 16'h0000, 16'h0000, 32'h0002_0000);  // enables idle
        add_row(K_RD,   16'h0014, 16'h0000, 16'h0000, 32'h0014_0000);  // past ro end
        add_row(K_RD,   16'h8000, 16'h0000, 16'h0000, 32'h8000_4567);  // rw magic
        add_row(K_RD,   16'h8004, 16'h0000, 16'h0000, 32'h8004_1000);  // rw bytecount
        add_row(K_RD,   16'h800c, 16'h0000, 16'h0000, 32'h800c_00f0);  // byte_en default
        add_row(K_RD,   16'h800f, 16'h0000, 16'h0000, 32'h800f_0000);  // straddles rw end
        add_row(K_WR,   16'h8008, 16'h0ff0, 16'habcd, 32'h0);          // masked di write
        add_row(K_RD,   16'h8008, 16'h0000, 16'h0000, 32'h8008_c00b);  // next cycle sees it
        add_row(K_WR,   16'h800a, 16'hffff, 16'h1234, 32'h0);
        add_row(K_RD,   16'h800a, 16'h0000, 16'h0000, 32'h800a_3412);
        add_row(K_WR,   16'h0008, 16'hffff, 16'hbeef, 32'h0);          // ro address is dropped
        add_row(K_RD,   16'h8008, 16'h0000, 16'h0000, 32'h8008_c00b);  // rw di unchanged
        add_row(K_WR,   16'h800c, 16'hffff, 16'hc01b, 32'h0);          // dwaddr 1b, byte_en c
        add_row(K_RD,   16'h800c, 16'h0000, 16'h0000, 32'h800c_1bc0);
        add_row(K_WR,   16'h8002, 16'h0001, 16'h0001, 32'h0);          // rd start
        add_row(K_RD,   16'h8002, 16'h0000, 16'h0000, 32'h8002_0000);  // start bits read 0
        add_row(K_POLL, 16'h000c, 16'h0000, 16'h0000, 32'h000c_1bc8);  // valid, dwaddr, byte_en
        add_row(K_RD,   16'h0010, 16'h0000, 16'h0000, 32'h0010_1b1b);  // 1b1b1b1b ^ a57e0000
        add_row(K_RD,   16'h0013, 16'h0000, 16'h0000, 32'h0013_be00);
        add_row(K_WR,   16'h8008, 16'hffff, 16'h5a3c, 32'h0);          // di 96015a3c
        add_row(K_WR,   16'h800a, 16'hffff, 16'h9601, 32'h0);
        add_row(K_WR,   16'h800c, 16'hffff, 16'h3555, 32'h0);          // dwaddr 155, byte_en 3
        add_row(K_WR,   16'h8002, 16'h0002, 16'h0002, 32'h0);          // wr start
        add_row(K_RD,   16'h8002, 16'h0000, 16'h0000, 32'h8002_0000);  // lets stale valid clear
        add_row(K_POLL, 16'h000c, 16'h0000, 16'h0000, 32'h000c_5539);
        add_row(K_RD,   16'h0008, 16'h0000, 16'h0000, 32'h0008_3cba);  // bus, dev and fn
        add_row(K_RD,   16'h000a, 16'h0000, 16'h0000, 32'h000a_0604);  // command register
    endtask

    // ----------------------------------------------------------------------
    // drive and check
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        n_tests++;
        assert (got === exp)
            $display("%s ok", name);
        else
        begin
            $display("Error: %0d ns %s expected %h got %h", $time, name, exp, got);
            n_errors++;
        end
    endtask

    // advances one clock and collects read responses in order
    task automatic next_cycle();
        int          idx;
        int          due;
        logic [31:0] exp;
        @(negedge clk_pcie);
        cmd_valid = 1'b0;
        if (rsp_valid && exp_q.size() == 0)
        begin
            $display("read response at %0d ns with no read outstanding", $time);
            n_errors++;
        end
        else if (rsp_valid)
        begin
            idx = idx_q.pop_front();
            exp = exp_q.pop_front();
            due = due_q.pop_front();
            assert (due == cycles)
            else
            begin
                $display("row %0d: read response in cycle %0d, due in cycle %0d",
                         idx, cycles, due);
                n_errors++;
            end
            if (idx < 0)
                last_poll = rsp_data;                      // judged by the poll loop
            else
                check_value($sformatf("row %0d o_rsp_data", idx), 64'(exp), 64'(rsp_data));
        end
    endtask

    task automatic send_cmd(input kind_t kind, input logic [15:0] addr,
                            input logic [15:0] mask, input logic [15:0] value);
        cmd_valid = 1'b1;
        cmd_word  = {value[7:0], value[15:8], mask[7:0], mask[15:8], addr,
                     (kind == K_WR) ? 16'h2000 : 16'h1000};    // swapped mask and value
        if (kind == K_RD)
            due_q.push_back(cycles + 2);                   // decode edge plus response edge
        next_cycle();
    endtask

    task automatic poll_result(input int idx, input logic [31:0] exp);
        int tries;
        tries     = 0;
        last_poll = '0;
        while (exp_q.size() != 0)
            next_cycle();
        while (!last_poll[3] && tries < poll_limit)       // result valid is byte 13 bit 3
        begin
            idx_q.push_back(-1);
            exp_q.push_back(32'h0);
            send_cmd(K_RD, 16'h000c, 16'h0000, 16'h0000);
            while (exp_q.size() != 0)
                next_cycle();
            tries++;
        end
        if (!last_poll[3])
        begin
            $display("row %0d: result valid never set after %0d reads", idx, tries);
            n_tests++;
            n_errors++;
        end
        else
            check_value($sformatf("row %0d poll o_rsp_data", idx), 64'(exp), 64'(last_poll));
    endtask

    task automatic run_row(input int idx);
        row_t r;
        r = rows[idx];
        if (r.kind == K_POLL)
            poll_result(idx, r.exp);
        else if (r.kind == K_RD)
        begin
            idx_q.push_back(idx);
            exp_q.push_back(r.exp);
            send_cmd(K_RD, r.addr, r.mask, r.value);
        end
        else
        begin
            send_cmd(K_WR, r.addr, r.mask, r.value);
            $display("row %0d write %h mask %h value %h sent", idx, r.addr, r.mask, r.value);
        end
    endtask

    initial
    begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_word  = '0;
        status    = {8'h3c, 5'h1a, 3'h5, 16'h0406};       // bus, device, func, command
        build_table();
        cycle_limit = rows.size() * poll_limit * 12 + 100;
        repeat (5) @(posedge clk_pcie);
        @(negedge clk_pcie);
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++)
            run_row(i);
        while (exp_q.size() != 0)
            next_cycle();
        check_value("core model write record", {18'd0, 32'h9601_5a3c, 10'h155, 4'h3},
                    {18'd0, last_di, last_dwaddr, last_byte_en});
        check_value("o_cfg_mgmt", {14'd0, 2'b00, 32'h9601_5a3c, 10'h155, 2'b10, 4'h3},
                    64'(cfg_mgmt));                        // enables idle, wr_readonly set
        check_value("o_pcie_id", 64'h0000_0000_0000_ba3c, 64'(pcie_id));   // func, dev, bus
        $display("tests %0d, errors %0d", n_tests, n_errors);
        if (n_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: verif/tb_cfg_core_model.sv
module tb_cfg_core_model
    import pcie_cfg_pkg::*;
(
    input  logic          clk_pcie,
    input  logic          rst,
    input  cfg_mgmt_req_t i_cfg_mgmt,
    output logic [31:0]   o_do,
    output logic          o_done,
    output logic [31:0]   o_last_di,                       // last write request seen
    output logic [9:0]    o_last_dwaddr,
    output logic [3:0]    o_last_byte_en
);
    timeunit 1ns;
    timeprecision 1ps;

    int   seed;                                            // done delay generator
    int   wait_cnt;
    logic pending;

    initial
    begin
        seed           = 32'h77db_32e0;
        wait_cnt       = 0;
        pending        = 1'b0;
        o_do           = '0;
        o_done         = 1'b0;
        o_last_di      = '0;
        o_last_dwaddr  = '0;
        o_last_byte_en = '0;
        forever
        begin
            @(negedge clk_pcie);
            if (rst)
            begin
                o_done  = 1'b0;
                pending = 1'b0;
            end
            else if (o_done)
            begin
                o_done = 1'b0;                             // single cycle done
            end
            else if (!pending && (i_cfg_mgmt.rd_en || i_cfg_mgmt.wr_en))
            begin
                pending  = 1'b1;
                wait_cnt = 3 + ({$random(seed)} % 8);      // 3 to 10 cycles
                if (i_cfg_mgmt.wr_en)
                begin
                    o_last_di      = i_cfg_mgmt.di;
                    o_last_dwaddr  = i_cfg_mgmt.dwaddr;
                    o_last_byte_en = i_cfg_mgmt.byte_en;
                end
            end
            else if (pending)
            begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0)
                begin
                    o_do    = ({22'd0, i_cfg_mgmt.dwaddr} * 32'h0101_0101) ^ 32'ha57e_0000;
                    o_done  = 1'b1;
                    pending = 1'b0;
                end
            end
        end
    end

endmodule

// File: verilog/pcie_cfg_top.sv
module pcie_cfg_top
    import pcie_cfg_pkg::*;
(
    input  logic          clk_pcie,
    input  logic          rst,
    input  logic          i_cmd_valid,
    input  logic [63:0]   i_cmd_word,
    input  cfg_status_t   i_status,
    input  logic [31:0]   i_cfg_mgmt_do,
    input  logic          i_cfg_mgmt_rd_wr_done,
    output cfg_mgmt_req_t o_cfg_mgmt,
    output logic          o_rsp_valid,
    output logic [31:0]   o_rsp_data,
    output logic [15:0]   o_pcie_id
);

    cfg_cmd_t       cmd;                                   // decoded strobe
    cfg_mgmt_ctrl_t ctrl;                                  // rw request fields
    cfg_result_t    result;
    logic           rd_start;
    logic           wr_start;
    logic           rd_en_lvl;
    logic           wr_en_lvl;

    // ----------------------------------------------------------------------
    // decode, register file, sequencer
    // ----------------------------------------------------------------------
    cfg_cmd_decode u_decode (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd_word  (i_cmd_word),
        .o_cmd       (cmd)
    );

    cfg_csr_file u_csr (
        .clk_pcie     (clk_pcie),
        .rst          (rst),
        .i_cmd        (cmd),
        .i_status     (i_status),
        .i_result     (result),
        .i_mgmt_rd_en (rd_en_lvl),
        .i_mgmt_wr_en (wr_en_lvl),
        .o_ctrl       (ctrl),
        .o_rd_start   (rd_start),
        .o_wr_start   (wr_start),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_data   (o_rsp_data),
        .o_pcie_id    (o_pcie_id)
    );

    cfg_mgmt_seq u_seq (
        .clk_pcie              (clk_pcie),
        .rst                   (rst),
        .i_ctrl                (ctrl),
        .i_rd_start            (rd_start),
        .i_wr_start            (wr_start),
        .i_cfg_mgmt_do         (i_cfg_mgmt_do),
        .i_cfg_mgmt_rd_wr_done (i_cfg_mgmt_rd_wr_done),
        .o_cfg_mgmt            (o_cfg_mgmt),
        .o_result              (result),
        .o_rd_en_lvl           (rd_en_lvl),
        .o_wr_en_lvl           (wr_en_lvl)
    );

endmodule

// File: verilog/cfg_mgmt_seq.sv
module cfg_mgmt_seq
    import pcie_cfg_pkg::*;
(
    input  logic           clk_pcie,
    input  logic           rst,
    input  cfg_mgmt_ctrl_t i_ctrl,
    input  logic           i_rd_start,
    input  logic           i_wr_start,
    input  logic [31:0]    i_cfg_mgmt_do,
    input  logic           i_cfg_mgmt_rd_wr_done,
    output cfg_mgmt_req_t  o_cfg_mgmt,
    output cfg_result_t    o_result,
    output logic           o_rd_en_lvl,
    output logic           o_wr_en_lvl
);

    logic        rd_en_q;                                  // held until done
    logic        wr_en_q;
    logic        busy;
    cfg_result_t result_q;

    assign busy = rd_en_q | wr_en_q;

    // ----------------------------------------------------------------------
    // enable until done
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_pcie)
    begin
        if (i_cfg_mgmt_rd_wr_done)
        begin
            result_q.dwaddr  <= i_ctrl.dwaddr;             // fields of the finished request
            result_q.byte_en <= i_ctrl.byte_en;
            result_q.data    <= i_cfg_mgmt_do;
        end
        if (rst)
        begin
            rd_en_q        <= 1'b0;
            wr_en_q        <= 1'b0;
            result_q.valid <= 1'b0;
        end
        else if (i_cfg_mgmt_rd_wr_done)
        begin
            rd_en_q        <= 1'b0;                        // op finished
            wr_en_q        <= 1'b0;
            result_q.valid <= 1'b1;
        end
        else if (!busy)
        begin
            if (i_rd_start)
            begin
                rd_en_q        <= 1'b1;
                result_q.valid <= 1'b0;                    // old result stale
            end
            else if (i_wr_start)
            begin
                wr_en_q        <= 1'b1;
                result_q.valid <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // core side
    // ----------------------------------------------------------------------
    assign o_cfg_mgmt.rd_en         = rd_en_q & ~i_cfg_mgmt_rd_wr_done;  // drop same cycle
    assign o_cfg_mgmt.wr_en         = wr_en_q & ~i_cfg_mgmt_rd_wr_done;
    assign o_cfg_mgmt.di            = i_ctrl.di;
    assign o_cfg_mgmt.dwaddr        = i_ctrl.dwaddr;
    assign o_cfg_mgmt.wr_readonly   = i_ctrl.wr_readonly;
    assign o_cfg_mgmt.wr_rw1c_as_rw = i_ctrl.wr_rw1c_as_rw;
    assign o_cfg_mgmt.byte_en       = i_ctrl.byte_en;

    assign o_result    = result_q;
    assign o_rd_en_lvl = o_cfg_mgmt.rd_en;                 // for the ro view
    assign o_wr_en_lvl = o_cfg_mgmt.wr_en;

    a_excl_en : assert property (@(posedge clk_pcie) disable iff (rst)
        !(o_cfg_mgmt.rd_en && o_cfg_mgmt.wr_en))
        else $error("cfg_mgmt read and write enabled together");

    // core must only answer a request we made
    a_done_busy : assert property (@(posedge clk_pcie) disable iff (rst)
        i_cfg_mgmt_rd_wr_done |-> busy)
        else $error("cfg_mgmt done without a pending request");

endmodule

// File: verilog/cfg_csr_file.sv
module cfg_csr_file
    import pcie_cfg_pkg::*;
(
    input  logic           clk_pcie,
    input  logic           rst,
    input  cfg_cmd_t       i_cmd,
    input  cfg_status_t    i_status,
    input  cfg_result_t    i_result,
    input  logic           i_mgmt_rd_en,
    input  logic           i_mgmt_wr_en,
    output cfg_mgmt_ctrl_t o_ctrl,
    output logic           o_rd_start,
    output logic           o_wr_start,
    output logic           o_rsp_valid,
    output logic [31:0]    o_rsp_data,
    output logic [15:0]    o_pcie_id
);

    logic [RW_BITS-1:0] rw_q;                              // read-write bytes
    logic [RO_BITS-1:0] ro_v;                              // read-only view
    logic [17:0]        addr_bit;                          // byte address in bits

    // ----------------------------------------------------------------------
    // read-only view
    // ----------------------------------------------------------------------
    assign ro_v[15:0]                       = RO_MAGIC;
    assign ro_v[RO_POS_MGMT_EN]             = i_mgmt_rd_en;      // live enable levels
    assign ro_v[RO_POS_MGMT_EN + 1]         = i_mgmt_wr_en;
    assign ro_v[31:18]                      = '0;
    assign ro_v[RO_POS_BYTECOUNT +: 32]     = 32'(RO_BYTES);
    assign ro_v[RO_POS_STATUS +: 8]         = i_status.bus;
    assign ro_v[RO_POS_STATUS + 8 +: 5]     = i_status.device;
    assign ro_v[RO_POS_STATUS + 13 +: 3]    = i_status.func;
    assign ro_v[RO_POS_STATUS + 16 +: 16]   = i_status.command;
    assign ro_v[RO_POS_RESULT +: 10]        = i_result.dwaddr;   // last cfg access
    assign ro_v[RO_POS_RESULT + 10]         = 1'b0;
    assign ro_v[RO_POS_RESULT + 11]         = i_result.valid;    // host polls this
    assign ro_v[RO_POS_RESULT + 12 +: 4]    = i_result.byte_en;
    assign ro_v[127:112]                    = '0;
    assign ro_v[RO_POS_RESULT_DATA +: 32]   = i_result.data;

    assign o_pcie_id = ro_v[RO_POS_STATUS +: 16];          // bus, dev, fn

    // ----------------------------------------------------------------------
    // masked write path
    // ----------------------------------------------------------------------
    logic [RW_BITS-1:0] mask_sh;                           // mask moved to address
    logic [RW_BITS-1:0] value_sh;
    logic [RW_BITS-1:0] wr_bits;                           // bits actually stored
    logic               rd_hit;
    logic               wr_hit;

    assign addr_bit = {i_cmd.byte_addr, 3'b000};
    assign mask_sh  = RW_BITS'(i_cmd.mask) << addr_bit;    // past the end falls off
    assign value_sh = RW_BITS'(i_cmd.value) << addr_bit;
    assign wr_bits  = mask_sh & RW_WR_MASK;                 // fixed fields protected

    // start bits are not stored, only sensed
    assign rd_hit = i_cmd.wr & mask_sh[RW_POS_RD_START] & value_sh[RW_POS_RD_START];
    assign wr_hit = i_cmd.wr & mask_sh[RW_POS_WR_START] & value_sh[RW_POS_WR_START];

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            rw_q       <= RW_RESET;
            o_rd_start <= 1'b0;
            o_wr_start <= 1'b0;
        end
        else
        begin
            if (i_cmd.wr)
            begin
                rw_q <= (rw_q & ~wr_bits) | (value_sh & wr_bits);
            end
            o_rd_start <= rd_hit;
            o_wr_start <= wr_hit & ~rd_hit;                // read start takes priority
        end
    end

    // request fields toward the sequencer
    assign o_ctrl.di            = rw_q[RW_POS_MGMT_DI +: 32];
    assign o_ctrl.dwaddr        = rw_q[RW_POS_MGMT_CTRL +: 10];
    assign o_ctrl.wr_readonly   = rw_q[RW_POS_MGMT_CTRL + 10];
    assign o_ctrl.wr_rw1c_as_rw = rw_q[RW_POS_MGMT_CTRL + 11];
    assign o_ctrl.byte_en       = rw_q[RW_POS_MGMT_CTRL + 12 +: 4];

    // ----------------------------------------------------------------------
    // read mux and response
    // ----------------------------------------------------------------------
    logic [RO_BITS-1:0] ro_win;                            // region shifted to address
    logic [RW_BITS-1:0] rw_win;
    logic [15:0]        rd_word;                           // little endian pair

    assign ro_win  = ro_v >> addr_bit;                     // out of range reads 0
    assign rw_win  = rw_q >> addr_bit;
    assign rd_word = i_cmd.is_rw ? rw_win[15:0] : ro_win[15:0];

    always_ff @(posedge clk_pcie)
    begin
        if (i_cmd.rd)
        begin
            // address echo, then byte at address, then next byte
            o_rsp_data <= {i_cmd.is_rw, i_cmd.byte_addr, rd_word[7:0], rd_word[15:8]};
        end
        if (rst)
        begin
            o_rsp_valid <= 1'b0;
        end
        else
        begin
            o_rsp_valid <= i_cmd.rd;                       // one pulse per read
        end
    end

    // sequencer would otherwise see two launches at once
    a_one_start : assert property (@(posedge clk_pcie) disable iff (rst)
        !(o_rd_start && o_wr_start))
        else $error("read and write start pulsed together");

endmodule

// File: verilog/cfg_cmd_decode.sv
module cfg_cmd_decode
    import pcie_cfg_pkg::*;
(
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_cmd_valid,
    input  logic [63:0] i_cmd_word,
    output cfg_cmd_t    o_cmd
);

    // ----------------------------------------------------------------------
    // field split
    // ----------------------------------------------------------------------
    logic [15:0] addr_f;                                   // address as received
    logic        type_rd;
    logic        type_wr;
    logic [15:0] mask_f;
    logic [15:0] value_f;

    assign addr_f  = i_cmd_word[CMD_POS_ADDR +: 16];
    assign type_rd = i_cmd_word[CMD_TYPE_READ];
    assign type_wr = i_cmd_word[CMD_TYPE_WRITE];
    assign mask_f  = {i_cmd_word[CMD_POS_MASK +: 8], i_cmd_word[CMD_POS_MASK + 8 +: 8]};
    assign value_f = {i_cmd_word[CMD_POS_VALUE +: 8], i_cmd_word[CMD_POS_VALUE + 8 +: 8]};

    // ----------------------------------------------------------------------
    // command register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_pcie)
    begin
        o_cmd.is_rw     <= addr_f[15];                     // region select
        o_cmd.byte_addr <= addr_f[14:0];
        o_cmd.mask      <= mask_f;
        o_cmd.value     <= value_f;
        if (rst)
        begin
            o_cmd.rd <= 1'b0;
            o_cmd.wr <= 1'b0;
        end
        else
        begin
            o_cmd.rd <= i_cmd_valid & type_rd;             // read wins if both type bits set
            o_cmd.wr <= i_cmd_valid & type_wr & ~type_rd & addr_f[15];  // ro writes dropped
        end
    end

    // downstream relies on one command kind per strobe
    a_one_kind : assert property (@(posedge clk_pcie) disable iff (rst)
        !(o_cmd.rd && o_cmd.wr))
        else $error("decode issued read and write together");

endmodule

// File: verilog/pcie_cfg_pkg.sv
package pcie_cfg_pkg;

    // ----------------------------------------------------------------------
    // register map
    // ----------------------------------------------------------------------
    localparam logic [15:0] RO_MAGIC         = 16'h2301;   // ro byte 0
    localparam logic [15:0] RW_MAGIC         = 16'h6745;   // rw byte 0, reset value
    localparam int          RO_BYTES         = 20;         // also ro bytecount field
    localparam int          RW_BYTES         = 16;         // also rw bytecount field
    localparam int          RO_BITS          = RO_BYTES * 8;
    localparam int          RW_BITS          = RW_BYTES * 8;

    localparam int          RW_POS_RD_START  = 16;         // byte 2, write one to start
    localparam int          RW_POS_WR_START  = 17;         // reads back as 0
    localparam int          RW_POS_MGMT_DI   = 64;         // bytes 8..11
    localparam int          RW_POS_MGMT_CTRL = 96;         // bytes 12..13

    localparam int          RO_POS_MGMT_EN     = 16;       // rd_en, then wr_en
    localparam int          RO_POS_BYTECOUNT   = 32;       // bytes 4..7
    localparam int          RO_POS_STATUS      = 64;       // bytes 8..11
    localparam int          RO_POS_RESULT      = 96;       // bytes 12..13
    localparam int          RO_POS_RESULT_DATA = 128;      // bytes 16..19

    localparam logic [15:0] MGMT_CTRL_RESET  = 16'hf000;   // byte_en all set

    // bits a masked write may touch; magic, start bits and bytecount excluded
    localparam logic [RW_BITS-1:0] RW_WR_MASK =
        128'hffff_ffff_ffff_ffff_0000_0000_fffc_0000;

    localparam logic [RW_BITS-1:0] RW_RESET =
        {16'h0000, MGMT_CTRL_RESET, 32'h0000_0000, 32'(RW_BYTES), 16'h0000, RW_MAGIC};

    // ----------------------------------------------------------------------
    // command word layout
    // ----------------------------------------------------------------------
    localparam int          CMD_TYPE_READ    = 12;
    localparam int          CMD_TYPE_WRITE   = 13;
    localparam int          CMD_POS_ADDR     = 16;         // 16 bit byte address
    localparam int          CMD_POS_MASK     = 32;         // byte swapped
    localparam int          CMD_POS_VALUE    = 48;         // byte swapped

    typedef struct packed {
        logic        rd;            // read strobe
        logic        wr;            // write strobe, rw region only
        logic        is_rw;         // address bit 15
        logic [14:0] byte_addr;
        logic [15:0] mask;          // already unswapped
        logic [15:0] value;
    } cfg_cmd_t;

    typedef struct packed {
        logic        rd_en;
        logic        wr_en;
        logic [31:0] di;
        logic [9:0]  dwaddr;
        logic        wr_readonly;
        logic        wr_rw1c_as_rw;
        logic [3:0]  byte_en;
    } cfg_mgmt_req_t;

    typedef struct packed {
        logic [31:0] di;
        logic [9:0]  dwaddr;
        logic        wr_readonly;
        logic        wr_rw1c_as_rw;
        logic [3:0]  byte_en;
    } cfg_mgmt_ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [9:0]  dwaddr;
        logic [3:0]  byte_en;
        logic [31:0] data;
    } cfg_result_t;

    typedef struct packed {
        logic [7:0]  bus;
        logic [4:0]  device;
        logic [2:0]  func;
        logic [15:0] command;       // cfg command register
    } cfg_status_t;

endpackage
